// File: run.sh
#!/usr/bin/env bash
# Build and run the quicksort engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -Wno-fatal \
    -f sources.f \
    --top-module tb_qs_sorter \
    -Mdir obj_dir; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/Vtb_qs_sorter 2>&1)
sim_status=$?
echo "$sim_out"

if [ "$sim_status" -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "Test passed" <<< "$sim_out"; then
  exit 0
else
  echo "Pass message not found in simulation output"
  exit 1
fi

// File: sources.f
+incdir+verilog
verilog/qs_pkg.sv
verilog/qs_ucode_rom.sv
verilog/qs_core.sv
verilog/qs_array_mem.sv
verilog/qs_sorter.sv
testbench/tb_clk_gen.sv
testbench/tb_qs_sorter.sv

// File: testbench/qs_golden.txt
# Each case is the element count, then 16 input words, then 16 expected words
# All values hex; entries past the count are expected to stay unchanged
10
fff0 fff4 fffa 0000 0001 0003 0007 000c 0010 0021 0040 0100 0123 1000 4000 7fff
fff0 fff4 fffa 0000 0001 0003 0007 000c 0010 0021 0040 0100 0123 1000 4000 7fff
10
00f0 00e0 00d0 00c0 00b0 00a0 0090 0080 0070 0060 0050 0040 0030 0020 0010 0000
0000 0010 0020 0030 0040 0050 0060 0070 0080 0090 00a0 00b0 00c0 00d0 00e0 00f0
10
5a5a 5a5a 5a5a 5a5a 5a5a 5a5a 5a5a 5a5a 5a5a 5a5a 5a5a 5a5a 5a5a 5a5a 5a5a 5a5a
5a5a 5a5a 5a5a 5a5a 5a5a 5a5a 5a5a 5a5a 5a5a 5a5a 5a5a 5a5a 5a5a 5a5a 5a5a 5a5a
10
ffff 8000 fffe c000 f000 8001 ff00 fff0 e000 a000 fffd 9000 f800 fc00 bfff d000
8000 8001 9000 a000 bfff c000 d000 e000 f000 f800 fc00 ff00 fff0 fffd fffe ffff
10
0003 fffb 7fff 8000 0000 ffff 0010 fff0 1234 edcc 0001 0002 fffe 4000 c000 0003
8000 c000 edcc fff0 fffb fffe ffff 0000 0001 0002 0003 0003 0010 1234 4000 7fff
0
0f0f 0e0e 0d0d 0c0c 0b0b 0a0a 0909 0808 0707 0606 0505 0404 0303 0202 0101 0000
0f0f 0e0e 0d0d 0c0c 0b0b 0a0a 0909 0808 0707 0606 0505 0404 0303 0202 0101 0000
1
7fff 8000 1111 2222 3333 4444 5555 6666 7777 8888 9999 aaaa bbbb cccc dddd eeee
7fff 8000 1111 2222 3333 4444 5555 6666 7777 8888 9999 aaaa bbbb cccc dddd eeee
5
0005 fffc 0002 0000 ffff 0001 0000 8000 7fff 1234 4321 0101 aaaa 5555 0f0f f0f0
fffc ffff 0000 0002 0005 0001 0000 8000 7fff 1234 4321 0101 aaaa 5555 0f0f f0f0
9
0064 ff9c 0032 ffce 0000 0019 ffe7 0064 ff9c c0de beef dead f00d 1357 2468 9bdf
ff9c ff9c ffce ffe7 0000 0019 0032 0064 0064 c0de beef dead f00d 1357 2468 9bdf

// File: testbench/tb_clk_gen.sv
/*
  Free-running 10 ns clock for the testbench, starts low.
*/
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk
);

  // Half period 5 ns
  initial begin
    clk = 1'b0;
    forever begin
      #5 clk = ~clk;
    end
  end

endmodule

// File: testbench/tb_qs_sorter.sv
/*
  Testbench for the quicksort engine. Golden cases come from
  testbench/qs_golden.txt, run from the project root. Random cases use a
  fixed seed. The run stops at the first mismatch.
*/
`timescale 1ns/1ps
`include "qs_params.svh"

module tb_qs_sorter import qs_pkg::*; ();

  localparam int         DW           = `QS_DATA_W;
  localparam int         N            = `QS_MAX_N;
  localparam int         GOLDEN_CASES = 9;
  localparam int         RAND_CASES   = 20;
  // Golden, random, reset check and early read
  localparam int         TOTAL_CASES  = GOLDEN_CASES + RAND_CASES + 2;
  localparam int         CASE_CYCLES  = 6000;
  localparam logic [4:0] CSR_ADR      = 5'h10;

  logic          clk;
  logic          rst_n;
  wb_req_t       wb_req;
  logic [DW-1:0] wb_dat_r;
  logic          wb_ack;

  logic [DW-1:0] in_words  [N];
  logic [DW-1:0] exp_words [N];
  integer        seed;

  tb_clk_gen u_clk (
    .clk (clk)
  );

  qs_sorter dut (
    .clk      (clk),
    .rst_n    (rst_n),
    .wb_req   (wb_req),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack)
  );

  task automatic fail_run(input string msg);
    $display("ERROR at %0t: %s", $time, msg);
    $display("Test failed");
    $fatal(1, "%s", msg);
  endtask

  task automatic check_value(input string name, input logic [DW-1:0] exp_v,
                             input logic [DW-1:0] act_v);
    if (exp_v !== act_v) begin
      $display("FAILED at %0t: %s expected %h, got %h", $time, name, exp_v, act_v);
      $display("Test failed");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  // Classic write, request held until ack
  task automatic write_word(input logic [4:0] adr, input logic [DW-1:0] data);
    @(negedge clk);
    wb_req.cyc   = 1'b1;
    wb_req.stb   = 1'b1;
    wb_req.we    = 1'b1;
    wb_req.adr   = adr;
    wb_req.dat_w = data;
    @(negedge clk);
    while (!wb_ack) begin
      @(negedge clk);
    end
    wb_req = '0;
  endtask

  // Classic read, data taken in the ack cycle
  task automatic read_word(input logic [4:0] adr, output logic [DW-1:0] data);
    @(negedge clk);
    wb_req.cyc   = 1'b1;
    wb_req.stb   = 1'b1;
    wb_req.we    = 1'b0;
    wb_req.adr   = adr;
    wb_req.dat_w = '0;
    @(negedge clk);
    while (!wb_ack) begin
      @(negedge clk);
    end
    data   = wb_dat_r;
    wb_req = '0;
  endtask

  task automatic load_array();
    for (int i = 0; i < N; i++) begin
      write_word(5'(i), in_words[i]);
    end
  endtask

  task automatic verify_array(input string tag);
    logic [DW-1:0] w;
    for (int i = 0; i < N; i++) begin
      read_word(5'(i), w);
      check_value($sformatf("%s arr[%0d]", tag, i), exp_words[i], w);
    end
  endtask

  // Start bit plus count, then busy set and done cleared
  task automatic start_sort(input int n);
    logic [DW-1:0] s;
    write_word(CSR_ADR, 16'h8000 | DW'(n));
    read_word(CSR_ADR, s);
    check_value("status after start", 16'h8000 | DW'(n), s);
  endtask

  // Poll status until done, then expect idle with no error
  task automatic wait_done(input int n);
    logic [DW-1:0] s;
    read_word(CSR_ADR, s);
    while (!s[14]) begin
      read_word(CSR_ADR, s);
    end
    check_value("status at done", 16'h4000 | DW'(n), s);
  endtask

  // Reference result, insertion sort on the first n words, signed
  task automatic sort_expected(input int n);
    logic [DW-1:0] key;
    int            k;
    for (int i = 0; i < N; i++) begin
      exp_words[i] = in_words[i];
    end
    for (int i = 1; i < n; i++) begin
      key = exp_words[i];
      k   = i - 1;
      while (k >= 0 && $signed(exp_words[k]) > $signed(key)) begin
        exp_words[k + 1] = exp_words[k];
        k--;
      end
      exp_words[k + 1] = key;
    end
  endtask

  task automatic random_fill();
    for (int i = 0; i < N; i++) begin
      in_words[i] = DW'($random(seed));
    end
  endtask

  // Next line that is neither blank nor a comment
  task automatic next_data_line(input int fd, output string line, output bit found);
    int rc;
    found = 1'b0;
    while (!found && !$feof(fd)) begin
      rc = $fgets(line, fd);
      // 8'h23 is the comment marker
      if (rc != 0 && line.len() > 1 && line.getc(0) != 8'h23) begin
        found = 1'b1;
      end
    end
  endtask

  task automatic run_golden();
    int            fd;
    int            rc;
    int            n;
    int            cases;
    bit            found;
    bit            ok;
    string         line;
    logic [DW-1:0] w;
    fd = $fopen("testbench/qs_golden.txt", "r");
    if (fd == 0) begin
      fail_run("cannot open testbench/qs_golden.txt");
    end else begin
      cases = 0;
      next_data_line(fd, line, found);
      while (found) begin
        ok = ($sscanf(line, "%h", n) == 1) && (n >= 0) && (n <= N);
        for (int i = 0; i < 2 * N; i++) begin
          rc = $fscanf(fd, "%h", w);
          ok = ok && (rc == 1);
          if (i < N) begin
            in_words[i] = w;
          end else begin
            exp_words[i - N] = w;
          end
        end
        if (!ok) begin
          fail_run($sformatf("golden case %0d is malformed", cases));
        end else begin
          load_array();
          start_sort(n);
          wait_done(n);
          verify_array($sformatf("golden %0d", cases));
          cases++;
          next_data_line(fd, line, found);
        end
      end
      $fclose(fd);
      if (cases != GOLDEN_CASES) begin
        fail_run($sformatf("golden file held %0d cases, %0d expected", cases, GOLDEN_CASES));
      end
    end
  endtask

  // Watchdog sized from the case count
  initial begin
    repeat (TOTAL_CASES * CASE_CYCLES) @(posedge clk);
    fail_run($sformatf("timeout after %0d cycles, a sort or bus access never ended",
                       TOTAL_CASES * CASE_CYCLES));
  end

  initial begin
    logic [DW-1:0] s;
    int            n;
    seed   = 32'h131f_37ff;
    rst_n  = 1'b0;
    wb_req = '0;
    repeat (8) @(negedge clk);
    rst_n = 1'b1;

    // Idle after reset, count cleared
    read_word(CSR_ADR, s);
    check_value("status after reset", 16'h0000, s);

    run_golden();

    // Array read issued during the sort waits for the result
    random_fill();
    n = N;
    sort_expected(n);
    load_array();
    write_word(CSR_ADR, 16'h8000 | DW'(n));
    read_word(5'd5, s);
    check_value("early read arr[5]", exp_words[5], s);
    read_word(CSR_ADR, s);
    check_value("status after early read", 16'h4000 | DW'(n), s);
    verify_array("early read");

    // Back to back random sorts
    for (int c = 0; c < RAND_CASES; c++) begin
      n = 2 + int'($unsigned($random(seed)) % 15);
      random_fill();
      sort_expected(n);
      load_array();
      start_sort(n);
      wait_done(n);
      verify_array($sformatf("random %0d", c));
    end

    $display("Test passed");
    $finish;
  end

endmodule

// File: verilog/qs_array_mem.sv
/*
  Array storage plus control/status register on a Wishbone classic port.
  The core owns the array while a sort is pending or running; host array
  cycles stall without ack until then. Count writes over QS_MAX_N saturate.
*/
`timescale 1ns/1ps
`include "qs_params.svh"

module qs_array_mem import qs_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  wb_req_t               wb_req,
  output logic [`QS_DATA_W-1:0] wb_dat_r,
  output logic                  wb_ack,
  input  core_mem_t             core_req,
  output logic [`QS_DATA_W-1:0] core_rdata,
  output logic                  start,
  output logic [`QS_IDX_W:0]    count,
  input  logic                  busy,
  input  logic                  done,
  input  logic                  err
);

  localparam int                 DW      = `QS_DATA_W;
  localparam logic [`QS_IDX_W:0] MAX_CNT = `QS_MAX_N;

  logic [DW-1:0]          arr [`QS_MAX_N];
  logic [DW-1:0]          rd_q;
  logic [DW-1:0]          stat_q;
  logic [DW-1:0]          status;
  logic [`QS_IDX_W-1:0]   rd_idx;
  logic [`QS_IDX_W:0]     cnt_in;
  logic                   sort_own;
  logic                   host_acc;
  logic                   csr_acc;
  logic                   arr_ok;
  logic                   ctl_wr;
  logic                   host_wr;
  logic                   csr_q;

  // Start pulse counts as busy so the host cannot slip in before the core
  assign sort_own = busy || start;

  // New access only when the previous ack has gone
  assign host_acc = wb_req.cyc && wb_req.stb && !wb_ack;
  assign csr_acc  = host_acc && wb_req.adr[`QS_IDX_W];
  assign arr_ok   = host_acc && !wb_req.adr[`QS_IDX_W] && !sort_own;
  assign ctl_wr   = csr_acc && wb_req.we && !sort_own;
  assign host_wr  = arr_ok && wb_req.we;

  assign cnt_in = wb_req.dat_w[`QS_IDX_W:0];

  // Single read port, core has it whenever it asks
  assign rd_idx = core_req.valid ? core_req.idx : wb_req.adr[`QS_IDX_W-1:0];

  // busy, done, err, then count in the low bits
  assign status = {sort_own, done && !start, err,
                   {(DW - 3 - (`QS_IDX_W + 1)){1'b0}}, count};

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wb_ack <= 1'b0;
      start  <= 1'b0;
      count  <= '0;
      csr_q  <= 1'b0;
    end else begin
      wb_ack <= csr_acc || arr_ok;
      start  <= ctl_wr && wb_req.dat_w[DW-1];
      if (csr_acc || arr_ok) begin
        csr_q <= csr_acc;
      end
      if (ctl_wr) begin
        count <= (cnt_in > MAX_CNT) ? MAX_CNT : cnt_in;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (core_req.valid && core_req.we) begin
      arr[core_req.idx] <= core_req.data;
    end else if (host_wr) begin
      arr[wb_req.adr[`QS_IDX_W-1:0]] <= wb_req.dat_w;
    end
    rd_q <= arr[rd_idx];
    if (csr_acc) begin
      stat_q <= status;
    end
  end

  assign core_rdata = rd_q;
  assign wb_dat_r   = csr_q ? stat_q : rd_q;

endmodule

// File: verilog/qs_core.sv
/*
  Microcode sequencer. One instruction at a time; LD spends a second cycle
  waiting for the synchronous array read. Stack overflow or underflow sets
  err and traps at the error label until reset.
*/
`timescale 1ns/1ps
`include "qs_params.svh"

module qs_core import qs_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  start,
  input  logic [`QS_IDX_W:0]    count,
  output pc_t                   pc,
  input  inst_t                 inst,
  output core_mem_t             mem_req,
  input  logic [`QS_DATA_W-1:0] mem_rdata,
  output logic                  busy,
  output logic                  done,
  output logic                  err
);

  localparam int DW   = `QS_DATA_W;
  // One extra bit so a full stack is distinguishable from empty
  localparam int SP_W = $clog2(`QS_STACK_D) + 1;

  logic [DW-1:0]   rf [8];
  logic [DW-1:0]   stack [`QS_STACK_D];
  logic [SP_W-1:0] sp;
  logic [SP_W-1:0] sp_m1;
  logic            z;
  logic            gt;
  logic            ld_wait;

  pc_t             pc_inc;
  logic [DW-1:0]   alu_a;
  logic [DW-1:0]   alu_b;
  logic [DW-1:0]   alu_res;
  logic [DW-1:0]   mov_val;
  logic [DW-1:0]   pop_data;
  logic            cc_hit;
  logic            is_push;
  logic            is_pop;
  logic            stk_full;
  logic            stk_empty;
  logic            stk_fault;
  logic            wr_en;
  reg_t            wr_sel;
  logic [DW-1:0]   wr_data;

  assign pc_inc = pc + 1'b1;

  // Stack bookkeeping, sp points at the next free slot
  assign sp_m1     = sp - 1'b1;
  assign pop_data  = stack[sp_m1[SP_W-2:0]];
  assign stk_full  = (sp == SP_W'(`QS_STACK_D));
  assign stk_empty = (sp == '0);
  assign is_push   = !ld_wait && (inst.jmp.op == OP_STK) && !inst.mem.dir;
  assign is_pop    = !ld_wait && (inst.jmp.op == OP_STK) && inst.mem.dir;
  assign stk_fault = (is_push && stk_full) || (is_pop && stk_empty);

  // ALU operands, immediate is zero-extended
  assign alu_a   = rf[inst.alu.src];
  assign alu_b   = inst.alu.imm ? DW'(inst.alu.opnd) : rf[inst.alu.opnd];
  assign alu_res = inst.alu.sub ? (alu_a - alu_b) : (alu_a + alu_b);

  // MOV source select
  always_comb begin
    if (inst.mv.spec) begin
      // hi = count - 1, wraps to -1 for an empty array
      mov_val = (inst.mv.src == REG_N) ? (DW'(count) - DW'(1)) : '0;
    end else if (inst.mv.imm) begin
      mov_val = DW'(inst.mv.src);
    end else begin
      mov_val = rf[inst.mv.src];
    end
  end

  always_comb begin
    case (inst.jmp.cc)
      AL:      cc_hit = 1'b1;
      EQ:      cc_hit = z;
      GT:      cc_hit = gt;
      default: cc_hit = !gt;
    endcase
  end

  // Register write port, one writer per cycle
  always_comb begin
    wr_en   = 1'b0;
    wr_sel  = inst.alu.dst;
    wr_data = alu_res;
    if (ld_wait) begin
      // Second LD cycle, read data is back
      wr_en   = 1'b1;
      wr_sel  = inst.mem.rd;
      wr_data = mem_rdata;
    end else begin
      case (inst.jmp.op)
        OP_ALU: wr_en = inst.alu.w;
        OP_MOV: begin
          wr_en   = 1'b1;
          wr_sel  = inst.mv.dst;
          wr_data = mov_val;
        end
        OP_STK: begin
          wr_en   = inst.mem.dir && !stk_empty;
          wr_sel  = inst.mem.rd;
          wr_data = pop_data;
        end
        OP_CALL: begin
          // Return address into BLINK
          wr_en   = !inst.mem.dir;
          wr_sel  = BLINK;
          wr_data = DW'(pc_inc);
        end
        default: wr_en = 1'b0;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      rf[wr_sel] <= wr_data;
    end
  end

  always_ff @(posedge clk) begin
    if (is_push && !stk_full) begin
      stack[sp[SP_W-2:0]] <= rf[inst.mem.ra];
    end
  end

  // Array port, issued in the first cycle of LD and the only cycle of ST
  always_comb begin
    mem_req = '0;
    if (!ld_wait && (inst.jmp.op == OP_MEM)) begin
      mem_req.valid = 1'b1;
      mem_req.we    = inst.mem.dir;
      mem_req.idx   = rf[inst.mem.ra][`QS_IDX_W-1:0];
      mem_req.data  = rf[inst.mem.rs];
    end
  end

  // Sequencer
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc      <= PC_RESET;
      sp      <= '0;
      z       <= 1'b0;
      gt      <= 1'b0;
      ld_wait <= 1'b0;
      busy    <= 1'b0;
      done    <= 1'b0;
      err     <= 1'b0;
    end else if (ld_wait) begin
      ld_wait <= 1'b0;
      pc      <= pc_inc;
    end else begin
      pc <= pc_inc;
      case (inst.jmp.op)
        OP_JCC: begin
          if (cc_hit) begin
            pc <= inst.jmp.target;
          end
        end
        OP_STK: begin
          if (stk_fault) begin
            pc   <= PC_ERR;
            err  <= 1'b1;
            busy <= 1'b0;
          end else if (is_push) begin
            sp <= sp + 1'b1;
          end else begin
            sp <= sp_m1;
          end
        end
        OP_MEM: begin
          // LD holds the PC one extra cycle
          if (!inst.mem.dir) begin
            ld_wait <= 1'b1;
            pc      <= pc;
          end
        end
        OP_ALU: begin
          // Compare only, signed order
          if (inst.alu.sub && !inst.alu.w) begin
            z  <= (alu_a == alu_b);
            gt <= ($signed(alu_a) > $signed(alu_b));
          end
        end
        OP_CALL: begin
          pc <= inst.mem.dir ? rf[BLINK][`QS_PC_W-1:0] : inst.jmp.target;
        end
        OP_SYS: begin
          if (!inst.mem.dir) begin
            // AWAIT spins until start
            if (start) begin
              busy <= 1'b1;
              done <= 1'b0;
            end else begin
              pc <= pc;
            end
          end else begin
            done <= 1'b1;
            busy <= 1'b0;
          end
        end
        default: pc <= pc_inc;
      endcase
    end
  end

endmodule

// File: verilog/qs_params.svh
/*
  Sizing for the quicksort engine. QS_IDX_W must equal clog2(QS_MAX_N);
  count and Wishbone address fields are QS_IDX_W+1 bits wide.
*/
`ifndef QS_PARAMS_SVH
`define QS_PARAMS_SVH

// Element width, signed two's complement
`define QS_DATA_W 16

// Array depth and its index width
`define QS_MAX_N 16
`define QS_IDX_W 4

// Microcode address width
`define QS_PC_W 8

// Call/data stack entries
// Worst-case recursion on 16 elements needs about 70
`define QS_STACK_D 128

`endif

// File: verilog/qs_pkg.sv
/*
  Types and microcode encoders for the quicksort sequencer.
  One 16-bit instruction word, four decode views sharing the opcode nibble.
*/
`include "qs_params.svh"

package qs_pkg;

  typedef logic [`QS_PC_W-1:0] pc_t;

  // R0..R6 general purpose, 7 is the link register
  typedef enum logic [2:0] {R0, R1, R2, R3, R4, R5, R6, BLINK} reg_t;

  // Always, equal, greater-than, less-or-equal
  typedef enum logic [1:0] {AL, EQ, GT, LE} cc_t;

  typedef enum logic [3:0] {
    OP_NOP  = 4'b0000,
    OP_JCC  = 4'b0001,
    OP_STK  = 4'b0010,
    OP_MEM  = 4'b0100,
    OP_MOV  = 4'b0110,
    OP_ALU  = 4'b0111,
    OP_CALL = 4'b1100,
    OP_SYS  = 4'b1111
  } op_t;

  // MOVS source code, reads count minus 1
  localparam logic [2:0] REG_N = 3'd0;

  // Fixed microcode entry points
  localparam pc_t PC_RESET = pc_t'(0);
  localparam pc_t PC_START = pc_t'(32);
  localparam pc_t PC_PART  = pc_t'(64);
  localparam pc_t PC_QSORT = pc_t'(96);
  localparam pc_t PC_ERR   = pc_t'(128);

  // Jcc and CALL target
  typedef struct packed {
    op_t        op;
    logic [1:0] rsvd;
    cc_t        cc;
    pc_t        target;
  } jmp_view_t;

  // ADD/SUB; with W clear only the flags change
  typedef struct packed {
    op_t        op;
    logic       sub;
    reg_t       dst;
    logic       w;
    reg_t       src;
    logic       imm;
    logic [2:0] opnd;
  } alu_view_t;

  // PUSH/POP, LD/ST, CALL/RET, AWAIT/DONE all keyed on dir
  typedef struct packed {
    op_t        op;
    logic       dir;
    reg_t       rd;
    logic       rsvd0;
    reg_t       rs;
    logic       rsvd1;
    reg_t       ra;
  } mem_view_t;

  // MOV, MOVI and MOVS
  typedef struct packed {
    op_t        op;
    logic       spec;
    reg_t       dst;
    logic [3:0] rsvd;
    logic       imm;
    logic [2:0] src;
  } mov_view_t;

  typedef union packed {
    jmp_view_t jmp;
    alu_view_t alu;
    mem_view_t mem;
    mov_view_t mv;
  } inst_t;

  // Wishbone classic master request
  typedef struct packed {
    logic                  cyc;
    logic                  stb;
    logic                  we;
    logic [`QS_IDX_W:0]    adr;
    logic [`QS_DATA_W-1:0] dat_w;
  } wb_req_t;

  // Core side of the array port
  typedef struct packed {
    logic                  valid;
    logic                  we;
    logic [`QS_IDX_W-1:0]  idx;
    logic [`QS_DATA_W-1:0] data;
  } core_mem_t;

  function automatic inst_t enc_mem(op_t op, logic dir, reg_t rd, reg_t rs, reg_t ra);
    inst_t i;
    i = '0;
    i.mem.op  = op;
    i.mem.dir = dir;
    i.mem.rd  = rd;
    i.mem.rs  = rs;
    i.mem.ra  = ra;
    return i;
  endfunction

  function automatic inst_t enc_alu(logic sb, reg_t d, reg_t s, logic w, logic im,
                                    logic [2:0] u);
    inst_t i;
    i = '0;
    i.alu.op   = OP_ALU;
    i.alu.sub  = sb;
    i.alu.dst  = d;
    i.alu.w    = w;
    i.alu.src  = s;
    i.alu.imm  = im;
    i.alu.opnd = u;
    return i;
  endfunction

  function automatic inst_t enc_mov(logic sp, reg_t d, logic im, logic [2:0] s);
    inst_t i;
    i = '0;
    i.mv.op   = OP_MOV;
    i.mv.spec = sp;
    i.mv.dst  = d;
    i.mv.imm  = im;
    i.mv.src  = s;
    return i;
  endfunction

  function automatic inst_t j(pc_t target, cc_t cc = AL);
    inst_t i;
    i = '0;
    i.jmp.op     = OP_JCC;
    i.jmp.cc     = cc;
    i.jmp.target = target;
    return i;
  endfunction

  // Same layout as a jump, dir bit clear
  function automatic inst_t call(pc_t target);
    inst_t i;
    i = j(target);
    i.jmp.op = OP_CALL;
    return i;
  endfunction

  function automatic inst_t ret();
    return enc_mem(OP_CALL, 1'b1, R0, R0, R0);
  endfunction

  function automatic inst_t push(reg_t r);
    return enc_mem(OP_STK, 1'b0, R0, R0, r);
  endfunction

  function automatic inst_t pop(reg_t r);
    return enc_mem(OP_STK, 1'b1, r, R0, R0);
  endfunction

  function automatic inst_t ld(reg_t d, reg_t a);
    return enc_mem(OP_MEM, 1'b0, d, R0, a);
  endfunction

  function automatic inst_t st(reg_t a, reg_t s);
    return enc_mem(OP_MEM, 1'b1, R0, s, a);
  endfunction

  function automatic inst_t mov(reg_t d, reg_t s);
    return enc_mov(1'b0, d, 1'b0, s);
  endfunction

  function automatic inst_t movi(reg_t d, logic [2:0] imm);
    return enc_mov(1'b0, d, 1'b1, imm);
  endfunction

  function automatic inst_t movs(reg_t d, logic [2:0] code);
    return enc_mov(1'b1, d, 1'b0, code);
  endfunction

  function automatic inst_t add(reg_t d, reg_t s, reg_t u, logic w = 1'b1);
    return enc_alu(1'b0, d, s, w, 1'b0, u);
  endfunction

  function automatic inst_t addi(reg_t d, reg_t s, logic [2:0] imm, logic w = 1'b1);
    return enc_alu(1'b0, d, s, w, 1'b1, imm);
  endfunction

  function automatic inst_t sub(reg_t d, reg_t s, reg_t u, logic w = 1'b1);
    return enc_alu(1'b1, d, s, w, 1'b0, u);
  endfunction

  function automatic inst_t subi(reg_t d, reg_t s, logic [2:0] imm, logic w = 1'b1);
    return enc_alu(1'b1, d, s, w, 1'b1, imm);
  endfunction

  function automatic inst_t await();
    return enc_mem(OP_SYS, 1'b0, R0, R0, R0);
  endfunction

  function automatic inst_t done();
    return enc_mem(OP_SYS, 1'b1, R0, R0, R0);
  endfunction

endpackage

// File: verilog/qs_sorter.sv
/*
  Quicksort engine top. Host loads the array, writes count with start,
  polls status for done, then reads the words back in signed order.
*/
`timescale 1ns/1ps
`include "qs_params.svh"

module qs_sorter import qs_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  wb_req_t               wb_req,
  output logic [`QS_DATA_W-1:0] wb_dat_r,
  output logic                  wb_ack
);

  pc_t                   pc;
  inst_t                 inst;
  core_mem_t             core_req;
  logic [`QS_DATA_W-1:0] core_rdata;
  logic [`QS_IDX_W:0]    count;
  logic                  start;
  logic                  busy;
  logic                  done;
  logic                  err;

  // Control store
  qs_ucode_rom u_rom (
    .ra   (pc),
    .rout (inst)
  );

  // Sequencer
  qs_core u_core (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (start),
    .count     (count),
    .pc        (pc),
    .inst      (inst),
    .mem_req   (core_req),
    .mem_rdata (core_rdata),
    .busy      (busy),
    .done      (done),
    .err       (err)
  );

  // Array and host register block
  qs_array_mem u_mem (
    .clk        (clk),
    .rst_n      (rst_n),
    .wb_req     (wb_req),
    .wb_dat_r   (wb_dat_r),
    .wb_ack     (wb_ack),
    .core_req   (core_req),
    .core_rdata (core_rdata),
    .start      (start),
    .count      (count),
    .busy       (busy),
    .done       (done),
    .err        (err)
  );

endmodule

// File: verilog/qs_ucode_rom.sv
/*
  Fixed control store, combinational. Unlisted addresses decode to a jump
  to the error label. Partition is Lomuto with pivot A[hi].
*/
`timescale 1ns/1ps

module qs_ucode_rom import qs_pkg::*; (
  input  pc_t   ra,
  output inst_t rout
);

  // Register use
  //   R0/R1 carry lo/hi in, partition returns pivot index in R0
  //   Quicksort keeps lo in R2, pivot in R3, hi in R4
  //   Partition keeps pivot value R2, i R3, j R4, A[j] R5, A[i] R6
  // Both routines save what they use on the stack

  always_comb begin
    case (ra)
      // Reset vector
      PC_RESET            : rout = j(PC_START);

      // Idle until the host starts a sort, then quicksort(0, n-1)
      PC_START            : rout = await();
      PC_START  + 8'd1    : rout = movi(R0, 3'd0);
      PC_START  + 8'd2    : rout = movs(R1, REG_N);
      PC_START  + 8'd3    : rout = call(PC_QSORT);
      PC_START  + 8'd4    : rout = done();
      PC_START  + 8'd5    : rout = j(PC_START);

      // Partition(lo, hi)
      PC_PART             : rout = push(R2);
      PC_PART   + 8'd1    : rout = push(R3);
      PC_PART   + 8'd2    : rout = push(R4);
      PC_PART   + 8'd3    : rout = push(R5);
      PC_PART   + 8'd4    : rout = push(R6);
      // pivot = A[hi], i = j = lo
      PC_PART   + 8'd5    : rout = ld(R2, R1);
      PC_PART   + 8'd6    : rout = mov(R3, R0);
      PC_PART   + 8'd7    : rout = mov(R4, R0);
      // Loop until j reaches hi
      PC_PART   + 8'd8    : rout = sub(R0, R1, R4, 1'b0);
      PC_PART   + 8'd9    : rout = j(PC_PART + 8'd19, EQ);
      PC_PART   + 8'd10   : rout = ld(R5, R4);
      // Skip swap when A[j] > pivot
      PC_PART   + 8'd11   : rout = sub(R0, R5, R2, 1'b0);
      PC_PART   + 8'd12   : rout = j(PC_PART + 8'd17, GT);
      PC_PART   + 8'd13   : rout = ld(R6, R3);
      PC_PART   + 8'd14   : rout = st(R3, R5);
      PC_PART   + 8'd15   : rout = st(R4, R6);
      PC_PART   + 8'd16   : rout = addi(R3, R3, 3'd1);
      PC_PART   + 8'd17   : rout = addi(R4, R4, 3'd1);
      PC_PART   + 8'd18   : rout = j(PC_PART + 8'd8);
      // Pivot into place, j == hi here
      PC_PART   + 8'd19   : rout = ld(R0, R3);
      PC_PART   + 8'd20   : rout = ld(R1, R4);
      PC_PART   + 8'd21   : rout = st(R3, R1);
      PC_PART   + 8'd22   : rout = st(R4, R0);
      PC_PART   + 8'd23   : rout = mov(R0, R3);
      PC_PART   + 8'd24   : rout = pop(R6);
      PC_PART   + 8'd25   : rout = pop(R5);
      PC_PART   + 8'd26   : rout = pop(R4);
      PC_PART   + 8'd27   : rout = pop(R3);
      PC_PART   + 8'd28   : rout = pop(R2);
      PC_PART   + 8'd29   : rout = ret();

      // Quicksort(lo, hi), recursive so BLINK is saved too
      PC_QSORT            : rout = push(BLINK);
      PC_QSORT  + 8'd1    : rout = push(R2);
      PC_QSORT  + 8'd2    : rout = push(R3);
      PC_QSORT  + 8'd3    : rout = push(R4);
      PC_QSORT  + 8'd4    : rout = mov(R2, R0);
      PC_QSORT  + 8'd5    : rout = mov(R4, R1);
      // Nothing to do when hi <= lo, signed so hi = -1 exits
      PC_QSORT  + 8'd6    : rout = sub(R0, R1, R0, 1'b0);
      PC_QSORT  + 8'd7    : rout = j(PC_QSORT + 8'd16, LE);
      PC_QSORT  + 8'd8    : rout = call(PC_PART);
      PC_QSORT  + 8'd9    : rout = mov(R3, R0);
      // Left half
      PC_QSORT  + 8'd10   : rout = mov(R0, R2);
      PC_QSORT  + 8'd11   : rout = subi(R1, R3, 3'd1);
      PC_QSORT  + 8'd12   : rout = call(PC_QSORT);
      // Right half
      PC_QSORT  + 8'd13   : rout = addi(R0, R3, 3'd1);
      PC_QSORT  + 8'd14   : rout = mov(R1, R4);
      PC_QSORT  + 8'd15   : rout = call(PC_QSORT);
      PC_QSORT  + 8'd16   : rout = pop(R4);
      PC_QSORT  + 8'd17   : rout = pop(R3);
      PC_QSORT  + 8'd18   : rout = pop(R2);
      PC_QSORT  + 8'd19   : rout = pop(BLINK);
      PC_QSORT  + 8'd20   : rout = ret();

      // Trap, held until reset
      PC_ERR              : rout = j(PC_ERR);

      default             : rout = j(PC_ERR);
    endcase
  end

endmodule
